/* hw/exec_defs.svh */
// sizing macros for the execute cluster, included by the package and by every module that sizes ports
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// physical register file depth
`define NUM_PR 32

// integer ALUs behind the CDB arbiter
`define NUM_FU 3

// datapath width
`define XLEN 64

// hard-wired zero register
// never written, reads back as zero
`define ZERO_PR 31

`endif

/* hw/exec_pkg.sv */
// shared types of the execute cluster, imported by each module that declares typed signals
`default_nettype none
`include "exec_defs.svh"

package exec_pkg;

  typedef logic [$clog2(`NUM_PR)-1:0] pr_idx_t;   // physical register tag
  typedef logic [`XLEN-1:0]           word_t;     // data word
  typedef logic [2:0]                 alu_op_t;   // alu opcode

  // alu opcode encodings
  localparam alu_op_t op_add  = 3'd0;
  localparam alu_op_t op_sub  = 3'd1;
  localparam alu_op_t op_and  = 3'd2;
  localparam alu_op_t op_or   = 3'd3;
  localparam alu_op_t op_xor  = 3'd4;
  localparam alu_op_t op_sll  = 3'd5;   // shift by low bits of src2
  localparam alu_op_t op_sltu = 3'd6;   // unsigned compare
  localparam alu_op_t op_pass = 3'd7;   // forward src1 unchanged

  typedef enum logic {
    fu_idle,                            // free for a new issue
    fu_hold                             // result waiting for the cdb
  } fu_state_t;

  // one operation offered to one unit
  typedef struct packed {
    logic    valid;
    alu_op_t op;
    pr_idx_t dest;
    pr_idx_t src1;
    pr_idx_t src2;
  } issue_t;

  // operand pair read for one unit
  typedef struct packed {
    word_t val1;
    word_t val2;
  } operands_t;

  // cdb broadcast, load write and held unit result
  typedef struct packed {
    logic    valid;
    pr_idx_t tag;
    word_t   value;
  } cdb_t;

endpackage

`default_nettype wire

/* hw/phys_reg_file.sv */
// physical register file with one cdb write port and forwarding operand reads for every alu
`timescale 1ns/1ps
`default_nettype none
`include "exec_defs.svh"

module phys_reg_file (
  input  wire                     clock,
  input  wire                     reset,
  input  wire exec_pkg::issue_t   issue [`NUM_FU],    // only source tags are read here
  input  wire exec_pkg::cdb_t     cdb,                // write port and forward source
  output exec_pkg::operands_t     operands [`NUM_FU]  // combinational per-unit reads
);

  import exec_pkg::*;

  localparam pr_idx_t zero_tag = pr_idx_t'(`ZERO_PR);

  word_t regs [`NUM_PR];   // storage array
  logic  wr_en;            // cdb write lands this cycle

  // writes to the zero register are dropped
  assign wr_en = cdb.valid && (cdb.tag != zero_tag);

  // one read port with write-through forwarding
  function automatic word_t read_port(input pr_idx_t tag);
    word_t rd;
    rd = regs[tag];                                    // stored value
    if (cdb.valid && (cdb.tag == tag) && (tag != zero_tag)) begin
      rd = cdb.value;                                  // bypass the broadcast
    end
    return rd;
  endfunction

  // two reads per unit
  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      operands[i].val1 = read_port(issue[i].src1);
      operands[i].val2 = read_port(issue[i].src2);
    end
  end

  // write port
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `NUM_PR; r++) begin
        regs[r] <= '0;                                 // all registers read zero
      end
    end else if (wr_en) begin
      regs[cdb.tag] <= cdb.value;                      // commit broadcast
    end
  end

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
// one integer functional unit, latches an issued op and holds its result until the cdb grants it
`timescale 1ns/1ps
`default_nettype none
`include "exec_defs.svh"

module alu_unit (
  input  wire                       clock,
  input  wire                       reset,
  input  wire exec_pkg::issue_t     issue,      // op for this unit
  input  wire exec_pkg::operands_t  operands,   // forwarded source values
  input  wire                       grant,      // from cdb arbiter
  output exec_pkg::cdb_t            result,     // held result request
  output logic                      busy        // no new issue accepted
);

  import exec_pkg::*;

  fu_state_t state;        // idle or holding
  pr_idx_t   tag_q;        // destination of held result
  word_t     value_q;      // held result value
  word_t     alu_value;    // combinational result
  logic      accept;       // issue taken this cycle

  assign accept = (state == fu_idle) && issue.valid;   // issues while busy are ignored

  always_comb begin
    case (issue.op)
      op_add:  alu_value = operands.val1 + operands.val2;
      op_sub:  alu_value = operands.val1 - operands.val2;
      op_and:  alu_value = operands.val1 & operands.val2;
      op_or:   alu_value = operands.val1 | operands.val2;
      op_xor:  alu_value = operands.val1 ^ operands.val2;
      op_sll:  alu_value = operands.val1 << operands.val2[$clog2(`XLEN)-1:0];
      op_sltu: alu_value = word_t'(operands.val1 < operands.val2);   // 0 or 1
      op_pass: alu_value = operands.val1;
      default: alu_value = '0;
    endcase
  end

  // idle -> hold on accept, hold -> idle on grant
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fu_idle;
    end else begin
      case (state)
        fu_idle: if (accept) state <= fu_hold;
        fu_hold: if (grant)  state <= fu_idle;   // free again next cycle
        default: state <= fu_idle;
      endcase
    end
  end

  // result payload, written only on accept
  always_ff @(posedge clock) begin
    if (accept) begin
      value_q <= alu_value;
      tag_q   <= issue.dest;
    end
  end

  always_comb begin
    result.valid = (state == fu_hold);   // request until granted
    result.tag   = tag_q;
    result.value = value_q;
    busy         = (state == fu_hold);
  end

endmodule

`default_nettype wire

/* hw/cdb_arbiter.sv */
// cdb arbiter, load writes win outright and the alu results share the rest in round-robin order
`timescale 1ns/1ps
`default_nettype none
`include "exec_defs.svh"

module cdb_arbiter (
  input  wire                   clock,
  input  wire                   reset,
  input  wire exec_pkg::cdb_t   load_wr,             // single-cycle load completion
  input  wire exec_pkg::cdb_t   results [`NUM_FU],   // held unit results
  output logic [`NUM_FU-1:0]    grant,               // one-hot unit grant
  output exec_pkg::cdb_t        cdb                  // the one broadcast this cycle
);

  localparam int ptr_w = ($clog2(`NUM_FU) > 0) ? $clog2(`NUM_FU) : 1;

  logic [ptr_w-1:0] rr_ptr;      // first unit searched
  logic [ptr_w-1:0] win_idx;     // first requester from rr_ptr
  logic             win_found;   // some unit is requesting
  int               cand;        // unit under test in the search

  // rotating search starting at rr_ptr
  always_comb begin
    win_found = 1'b0;
    win_idx   = '0;
    cand      = 0;
    for (int k = 0; k < `NUM_FU; k++) begin
      cand = (int'(rr_ptr) + k) % `NUM_FU;
      if (!win_found && results[cand].valid) begin
        win_found = 1'b1;
        win_idx   = cand[ptr_w-1:0];
      end
    end
  end

  // load has fixed priority, units get nothing that cycle
  always_comb begin
    grant = '0;
    cdb   = '0;
    if (load_wr.valid) begin
      cdb = load_wr;
    end else if (win_found) begin
      grant[win_idx] = 1'b1;
      cdb            = results[win_idx];
    end
  end

  // pointer moves one past the unit just granted
  always_ff @(posedge clock) begin
    if (reset) begin
      rr_ptr <= '0;
    end else if (|grant) begin
      if (win_idx == ptr_w'(`NUM_FU - 1)) begin
        rr_ptr <= '0;              // wrap
      end else begin
        rr_ptr <= win_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/exec_cluster.sv */
// execute cluster top, connects the register file, the row of alus and the cdb arbiter
`timescale 1ns/1ps
`default_nettype none
`include "exec_defs.svh"

module exec_cluster (
  input  wire                     clock,
  input  wire                     reset,
  input  wire exec_pkg::issue_t   issue [`NUM_FU],   // one op per unit per cycle
  input  wire exec_pkg::cdb_t     load_wr,           // external load completion
  output wire [`NUM_FU-1:0]       busy,              // unit holding a result
  output wire exec_pkg::cdb_t     cdb                // broadcast leaving the block
);

  import exec_pkg::*;

  wire operands_t       operands [`NUM_FU];   // register file to units
  wire cdb_t            results  [`NUM_FU];   // units to arbiter
  wire [`NUM_FU-1:0]    grant;                // arbiter to units

  phys_reg_file u_prf (
    .clock    (clock),
    .reset    (reset),
    .issue    (issue),
    .cdb      (cdb),        // write back the winning broadcast
    .operands (operands)
  );

  for (genvar i = 0; i < `NUM_FU; i++) begin : g_alu
    alu_unit u_alu (
      .clock    (clock),
      .reset    (reset),
      .issue    (issue[i]),
      .operands (operands[i]),
      .grant    (grant[i]),
      .result   (results[i]),
      .busy     (busy[i])
    );
  end

  cdb_arbiter u_arb (
    .clock   (clock),
    .reset   (reset),
    .load_wr (load_wr),
    .results (results),
    .grant   (grant),
    .cdb     (cdb)
  );

endmodule

`default_nettype wire

/* tests/exec_cluster_tb.sv */
// directed testbench that drives the execute cluster top and runs from project.f
`timescale 1ns/1ps
`default_nettype none
`include "exec_defs.svh"

module exec_cluster_tb;

  import exec_pkg::*;

  localparam int cycle_limit = 2000;   // far above the length of all tests

  logic              clock;
  logic              reset;
  issue_t            issue [`NUM_FU];   // per-unit issue strobes
  cdb_t              load_wr;           // external load completion
  wire [`NUM_FU-1:0] busy;
  wire cdb_t         cdb;

  word_t model [`NUM_PR];   // reference register contents
  int    seed;              // $random state
  int    cycles = 0;        // clock edges since start

  exec_cluster u_dut (
    .clock   (clock),
    .reset   (reset),
    .issue   (issue),
    .load_wr (load_wr),
    .busy    (busy),
    .cdb     (cdb)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock;   // 20 ns period

  // model follows every broadcast except to the zero register
  always @(negedge clock) begin
    if (!reset && cdb.valid && (cdb.tag != pr_idx_t'(`ZERO_PR))) begin
      model[cdb.tag] = cdb.value;
    end
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  task automatic report_failure(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "check failed");
  endtask

  // expected alu result from the opcode table
  function automatic word_t expected_result(input alu_op_t op, input word_t a, input word_t b);
    word_t r;
    case (op)
      3'd0: r = a + b;
      3'd1: r = a - b;
      3'd2: r = a & b;
      3'd3: r = a | b;
      3'd4: r = a ^ b;
      3'd5: r = a << b[5:0];                               // low 6 bits only
      3'd6: r = (a < b) ? word_t'(1) : word_t'(0);         // unsigned
      default: r = a;                                      // pass operand one
    endcase
    return r;
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = {$random(seed), $random(seed)};
    return w;
  endfunction

  // any tag below the zero register
  function automatic pr_idx_t rand_tag();
    int unsigned r;
    r = $unsigned($random(seed));
    return pr_idx_t'(r % (`NUM_PR - 1));
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;                      // drive point
  endtask

  task automatic set_issue(input int u, input alu_op_t op, input pr_idx_t dest,
                           input pr_idx_t s1, input pr_idx_t s2);
    issue[u].valid = 1'b1;
    issue[u].op    = op;
    issue[u].dest  = dest;
    issue[u].src1  = s1;
    issue[u].src2  = s2;
  endtask

  task automatic clear_issue(input int u);
    issue[u] = '0;
  endtask

  // waits for the next broadcast and returns at the following drive point
  task automatic expect_bcast(input pr_idx_t tag, input word_t value, input string what);
    @(negedge clock);
    while (!cdb.valid) begin
      @(negedge clock);
    end
    assert ((cdb.tag == tag) && (cdb.value == value)) else begin
      report_failure($sformatf("%s broadcast tag %0d value %h, expected tag %0d value %h",
                               what, cdb.tag, cdb.value, tag, value));
    end
    next_cycle();
  endtask

  task automatic do_load(input pr_idx_t tag, input word_t value);
    load_wr.valid = 1'b1;
    load_wr.tag   = tag;
    load_wr.value = value;
    expect_bcast(tag, value, "load");   // always granted in its own cycle
    load_wr = '0;
  endtask

  // one op on one idle unit while no other writer is active
  task automatic run_op(input int u, input alu_op_t op, input pr_idx_t dest,
                        input pr_idx_t s1, input pr_idx_t s2, output word_t exp_val);
    exp_val = expected_result(op, model[s1], model[s2]);
    assert (!busy[u]) else begin
      report_failure($sformatf("unit %0d busy before issue", u));
    end
    set_issue(u, op, dest, s1, s2);
    next_cycle();                       // accepted at this edge
    clear_issue(u);
    assert (busy[u]) else begin
      report_failure($sformatf("unit %0d not busy after issue", u));
    end
    expect_bcast(dest, exp_val, $sformatf("unit %0d op %0d", u, op));
  endtask

  task automatic check_reset_state();
    word_t got;
    assert (!cdb.valid && (busy == '0)) else begin
      report_failure("cdb valid or a unit busy after reset");
    end
    for (int r = 0; r < `NUM_PR; r++) begin
      run_op(r % `NUM_FU, 3'd7, pr_idx_t'(r), pr_idx_t'(r), pr_idx_t'(r), got);
    end
  endtask

  task automatic check_loads_and_ops();
    word_t   got;
    pr_idx_t dest;
    for (int r = 0; r < `NUM_PR - 1; r++) begin
      do_load(pr_idx_t'(r), rand_word());
    end
    for (int op = 0; op < 8; op++) begin
      for (int u = 0; u < `NUM_FU; u++) begin
        dest = rand_tag();
        run_op(u, alu_op_t'(op), dest, rand_tag(), rand_tag(), got);
        // read back through the next unit
        run_op((u + 1) % `NUM_FU, 3'd7, dest, dest, rand_tag(), got);
      end
    end
  endtask

  task automatic check_zero_register();
    word_t   got;
    word_t   v;
    pr_idx_t zero_tag;
    zero_tag = pr_idx_t'(`ZERO_PR);
    do_load(zero_tag, rand_word() | word_t'(1));       // nonzero so a stray write shows
    run_op(0, 3'd7, pr_idx_t'(5), zero_tag, zero_tag, got);
    run_op(1 % `NUM_FU, 3'd0, zero_tag, pr_idx_t'(1), pr_idx_t'(2), got);   // still broadcasts
    run_op(2 % `NUM_FU, 3'd3, pr_idx_t'(6), zero_tag, zero_tag, got);
    // read of the zero register during a load to it gets no bypass
    v = rand_word() | word_t'(1);
    load_wr.valid = 1'b1;
    load_wr.tag   = zero_tag;
    load_wr.value = v;
    set_issue(0, 3'd7, pr_idx_t'(7), zero_tag, zero_tag);
    expect_bcast(zero_tag, v, "load to zero register");
    load_wr = '0;
    clear_issue(0);
    expect_bcast(pr_idx_t'(7), '0, "read of zero register during its broadcast");
  endtask

  task automatic check_forwarding();
    word_t   v;
    word_t   exp_a;
    word_t   exp_b;
    pr_idx_t t;
    pr_idx_t other;
    t     = pr_idx_t'(7);
    other = pr_idx_t'(8);
    // load bypassed into unit 0
    v = rand_word();
    exp_a = v + model[other];
    load_wr.valid = 1'b1;
    load_wr.tag   = t;
    load_wr.value = v;
    set_issue(0, 3'd0, pr_idx_t'(9), t, other);
    expect_bcast(t, v, "load");
    load_wr = '0;
    clear_issue(0);
    expect_bcast(pr_idx_t'(9), exp_a, "add with forwarded load");
    // alu result bypassed into unit 1
    exp_a = model[t] ^ model[other];
    exp_b = model[other] - exp_a;        // must see the new t
    set_issue(0, 3'd4, t, t, other);
    next_cycle();
    clear_issue(0);
    set_issue(1 % `NUM_FU, 3'd1, pr_idx_t'(10), other, t);   // issued while t is on the cdb
    expect_bcast(t, exp_a, "xor");
    clear_issue(1 % `NUM_FU);
    expect_bcast(pr_idx_t'(10), exp_b, "sub with forwarded alu result");
  endtask

  // all units issue together while loads hold them off
  task automatic check_contention(input int loads);
    pr_idx_t dest    [`NUM_FU];
    word_t   exp_val [`NUM_FU];
    logic    seen    [`NUM_FU];
    pr_idx_t s1;
    pr_idx_t s2;
    alu_op_t op;
    word_t   v;
    int      found;
    for (int u = 0; u < `NUM_FU; u++) begin
      dest[u]    = pr_idx_t'(11 + u);    // distinct tags identify the unit
      s1         = rand_tag();
      s2         = rand_tag();
      op         = alu_op_t'($unsigned($random(seed)) % 8);
      exp_val[u] = expected_result(op, model[s1], model[s2]);
      seen[u]    = 1'b0;
      set_issue(u, op, dest[u], s1, s2);
    end
    next_cycle();                        // all accepted
    for (int u = 0; u < `NUM_FU; u++) begin
      clear_issue(u);
    end
    for (int k = 0; k < loads; k++) begin
      assert (busy == '1) else begin
        report_failure("a unit dropped its result during a load");
      end
      v = rand_word();
      do_load(pr_idx_t'(20 + k), v);     // load wins over every unit
    end
    for (int c = 0; c < `NUM_FU; c++) begin
      @(negedge clock);
      found = -1;
      for (int u = 0; u < `NUM_FU; u++) begin
        if (!seen[u] && cdb.valid && (cdb.tag == dest[u])) begin
          found = u;
        end
      end
      assert (found >= 0) else begin
        report_failure($sformatf("no pending unit result on the cdb in slot %0d", c));
      end
      assert (cdb.value == exp_val[found]) else begin
        report_failure($sformatf("unit %0d broadcast %h, expected %h",
                                 found, cdb.value, exp_val[found]));
      end
      for (int u = 0; u < `NUM_FU; u++) begin
        assert (busy[u] == !seen[u]) else begin
          report_failure($sformatf("unit %0d busy level wrong around its broadcast", u));
        end
      end
      seen[found] = 1'b1;
      next_cycle();
    end
    assert ((busy == '0) && !cdb.valid) else begin
      report_failure("units still busy after all results were broadcast");
    end
  endtask

  initial begin
    seed    = 87;
    reset   = 1'b1;
    load_wr = '0;
    for (int u = 0; u < `NUM_FU; u++) begin
      issue[u] = '0;
    end
    for (int r = 0; r < `NUM_PR; r++) begin
      model[r] = '0;                     // matches the cleared register file
    end
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    check_reset_state();
    check_loads_and_ops();
    check_zero_register();
    check_forwarding();
    check_contention(0);
    check_contention(2);
    check_contention(1);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/exec_pkg.sv
hw/phys_reg_file.sv
hw/alu_unit.sv
hw/cdb_arbiter.sv
hw/exec_cluster.sv
tests/exec_cluster_tb.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  - include_dirs:
      - hw
    files:
      - hw/exec_pkg.sv
      - hw/phys_reg_file.sv
      - hw/alu_unit.sv
      - hw/cdb_arbiter.sv
      - hw/exec_cluster.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/exec_cluster_tb.sv
